/* source/qs_pkg.sv */
package qs_pkg;

  // Life cycle of one bank, owned by the bank controller
  typedef enum logic [2:0] {
    // Free, waiting for the loader
    bank_idle,
    // Loader is writing words
    bank_loading,
    // Holds a full packet, not yet sorted
    bank_ready,
    // Sort engine owns the memory
    bank_sorting,
    // Sorted, waiting for the unloader
    bank_sorted,
    // Unloader is reading words
    bank_unloading
  } bank_status_t;

  // Loader FSM
  typedef enum logic {
    enq_idle,
    enq_load
  } enq_state_t;

  // Bubble-sort sequencer, one compare-and-swap per visit of read_a
  typedef enum logic [2:0] {
    sort_wait,
    sort_read_a,
    sort_read_b,
    sort_compare,
    sort_write_a,
    sort_write_b,
    sort_pass_end
  } sort_state_t;

  // Unloader FSM
  typedef enum logic {
    deq_idle,
    deq_unload
  } deq_state_t;

endpackage

/* source/qs_bank_ctrl.sv */
module qs_bank_ctrl #(
  parameter int max_words  = 16,
  parameter int bank_count = 2,
  localparam int cnt_w  = $clog2(max_words) + 1,
  localparam int bank_w = (bank_count > 1) ? $clog2(bank_count) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load_start,
  input  logic                 load_done,
  input  logic                 load_err,
  input  logic [cnt_w-1:0]     load_count,
  input  logic                 sort_start,
  input  logic                 sort_done,
  input  logic                 unload_start,
  input  logic                 unload_done,
  output qs_pkg::bank_status_t enq_status,
  output qs_pkg::bank_status_t sort_status,
  output qs_pkg::bank_status_t deq_status,
  output logic [cnt_w-1:0]     sort_count,
  output logic [cnt_w-1:0]     deq_count,
  output logic                 deq_err,
  output logic [bank_w-1:0]    enq_bank,
  output logic [bank_w-1:0]    sort_bank,
  output logic [bank_w-1:0]    deq_bank,
  output qs_pkg::bank_status_t bank_status_all [bank_count]
);
  import qs_pkg::*;

  bank_status_t status_q [bank_count];
  logic [cnt_w-1:0] count_q [bank_count];
  logic err_q [bank_count];

  // Round-robin step, wraps at the last bank
  function automatic logic [bank_w-1:0] next_bank(input logic [bank_w-1:0] b);
    if (b == bank_w'(bank_count - 1)) begin
      return '0;
    end
    return b + 1'b1;
  endfunction

  // Each pulse moves the status of its engine's bank one step on.
  // Engines never share a bank in the same status, so no priority
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < bank_count; i++) begin
        status_q[i] <= bank_idle;
      end
      enq_bank  <= '0;
      sort_bank <= '0;
      deq_bank  <= '0;
    end else begin
      if (load_start) begin
        status_q[enq_bank] <= bank_loading;
      end
      if (load_done) begin
        status_q[enq_bank] <= bank_ready;
        enq_bank <= next_bank(enq_bank);
      end
      if (sort_start) begin
        status_q[sort_bank] <= bank_sorting;
      end
      if (sort_done) begin
        status_q[sort_bank] <= bank_sorted;
        sort_bank <= next_bank(sort_bank);
      end
      if (unload_start) begin
        status_q[deq_bank] <= bank_unloading;
      end
      // Unloaded bank is free again
      if (unload_done) begin
        status_q[deq_bank] <= bank_idle;
        deq_bank <= next_bank(deq_bank);
      end
    end
  end

  // Word count and overflow flag travel with the packet
  always_ff @(posedge clk) begin
    if (load_done) begin
      count_q[enq_bank] <= load_count;
      err_q[enq_bank]   <= load_err;
    end
  end

  // Each engine sees only its current bank
  assign enq_status  = status_q[enq_bank];
  assign sort_status = status_q[sort_bank];
  assign deq_status  = status_q[deq_bank];
  assign sort_count  = count_q[sort_bank];
  assign deq_count   = count_q[deq_bank];
  assign deq_err     = err_q[deq_bank];

  // Memory steering needs every bank
  assign bank_status_all = status_q;

endmodule

/* source/qs_enqueue.sv */
module qs_enqueue #(
  parameter int word_width = 32,
  parameter int max_words  = 16,
  localparam int addr_w = $clog2(max_words),
  localparam int cnt_w  = addr_w + 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_vld,
  input  logic                  in_eop,
  input  logic [word_width-1:0] in_dat,
  output logic                  in_rdy,
  input  qs_pkg::bank_status_t  enq_status,
  output logic                  load_start,
  output logic                  load_done,
  output logic                  load_err,
  output logic [cnt_w-1:0]      load_count,
  output logic                  enq_en,
  output logic                  enq_wen,
  output logic [addr_w-1:0]     enq_addr,
  output logic [word_width-1:0] enq_din
);
  import qs_pkg::*;

  enq_state_t state_q;
  logic [cnt_w-1:0] cnt_q;
  logic ovf_q;
  logic take;
  logic room;

  // Ready only once the controller shows the bank as loading,
  // so the memory already routes our writes to it
  assign in_rdy = (state_q == enq_load) && (enq_status == bank_loading);
  assign take   = in_vld && in_rdy;
  assign room   = cnt_q < cnt_w'(max_words);

  // Words past max_words are accepted but dropped
  assign enq_en   = take && room;
  assign enq_wen  = 1'b1;
  assign enq_addr = cnt_q[addr_w-1:0];
  assign enq_din  = in_dat;

  // Held stable until the next claim, well after load_done
  assign load_count = cnt_q;
  assign load_err   = ovf_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= enq_idle;
      load_start <= 1'b0;
      load_done  <= 1'b0;
      cnt_q      <= '0;
      ovf_q      <= 1'b0;
    end else begin
      load_start <= 1'b0;
      load_done  <= 1'b0;
      case (state_q)
        enq_idle: begin
          // Claim the current bank once it is free
          if (enq_status == bank_idle) begin
            state_q    <= enq_load;
            load_start <= 1'b1;
            cnt_q      <= '0;
            ovf_q      <= 1'b0;
          end
        end
        enq_load: begin
          if (take) begin
            if (room) begin
              cnt_q <= cnt_q + 1'b1;
            end else begin
              ovf_q <= 1'b1;
            end
            if (in_eop) begin
              state_q   <= enq_idle;
              load_done <= 1'b1;
            end
          end
        end
        default: state_q <= enq_idle;
      endcase
    end
  end

endmodule

/* source/qs_sorter.sv */
module qs_sorter #(
  parameter int word_width = 32,
  parameter int max_words  = 16,
  localparam int addr_w = $clog2(max_words),
  localparam int cnt_w  = addr_w + 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  qs_pkg::bank_status_t  sort_status,
  input  logic [cnt_w-1:0]      sort_count,
  output logic                  sort_start,
  output logic                  sort_done,
  output logic                  sort_en,
  output logic                  sort_wen,
  output logic [addr_w-1:0]     sort_addr,
  output logic [word_width-1:0] sort_din,
  input  logic [word_width-1:0] sort_dout
);
  import qs_pkg::*;

  sort_state_t state_q;
  logic [addr_w-1:0] idx_q;
  logic swapped_q;
  // Left and right word of the current pair
  logic [word_width-1:0] a_q;
  logic [word_width-1:0] b_q;
  logic last;

  // Pair (idx, idx+1) is the final pair of this pass
  assign last = ({1'b0, idx_q} + cnt_w'(2)) == sort_count;

  // Memory request per state, read data returns one cycle later
  always_comb begin
    sort_en   = 1'b0;
    sort_wen  = 1'b0;
    sort_addr = idx_q;
    sort_din  = b_q;
    case (state_q)
      sort_read_a: sort_en = 1'b1;
      sort_read_b: begin
        sort_en   = 1'b1;
        sort_addr = idx_q + 1'b1;
      end
      // Swap, right word goes to the left slot
      sort_write_a: begin
        sort_en  = 1'b1;
        sort_wen = 1'b1;
      end
      sort_write_b: begin
        sort_en   = 1'b1;
        sort_wen  = 1'b1;
        sort_addr = idx_q + 1'b1;
        sort_din  = a_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state_q == sort_read_b) begin
      a_q <= sort_dout;
    end
    if (state_q == sort_compare) begin
      b_q <= sort_dout;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= sort_wait;
      sort_start <= 1'b0;
      sort_done  <= 1'b0;
      idx_q      <= '0;
      swapped_q  <= 1'b0;
    end else begin
      sort_start <= 1'b0;
      sort_done  <= 1'b0;
      case (state_q)
        sort_wait: begin
          if (sort_status == bank_ready) begin
            sort_start <= 1'b1;
            // Pretend a swap so pass_end starts the first pass.
            // One word is already sorted and ends at once
            swapped_q  <= sort_count > cnt_w'(1);
            state_q    <= sort_pass_end;
          end
        end
        sort_read_a: state_q <= sort_read_b;
        sort_read_b: state_q <= sort_compare;
        sort_compare: begin
          // Unsigned compare, left word in a_q, right on the read port
          if (a_q > sort_dout) begin
            swapped_q <= 1'b1;
            state_q   <= sort_write_a;
          end else if (last) begin
            state_q <= sort_pass_end;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= sort_read_a;
          end
        end
        sort_write_a: state_q <= sort_write_b;
        sort_write_b: begin
          if (last) begin
            state_q <= sort_pass_end;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= sort_read_a;
          end
        end
        sort_pass_end: begin
          // A clean pass means the bank is in order
          if (swapped_q) begin
            idx_q     <= '0;
            swapped_q <= 1'b0;
            state_q   <= sort_read_a;
          end else begin
            sort_done <= 1'b1;
            state_q   <= sort_wait;
          end
        end
        default: state_q <= sort_wait;
      endcase
    end
  end

endmodule

/* source/qs_dequeue.sv */
module qs_dequeue #(
  parameter int word_width = 32,
  parameter int max_words  = 16,
  localparam int addr_w = $clog2(max_words),
  localparam int cnt_w  = addr_w + 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  qs_pkg::bank_status_t  deq_status,
  input  logic [cnt_w-1:0]      deq_count,
  input  logic                  deq_err,
  output logic                  unload_start,
  output logic                  unload_done,
  output logic                  deq_en,
  output logic [addr_w-1:0]     deq_addr,
  input  logic [word_width-1:0] deq_dout,
  output logic                  out_vld,
  output logic                  out_sop,
  output logic                  out_eop,
  output logic                  out_err,
  output logic [word_width-1:0] out_dat
);
  import qs_pkg::*;

  deq_state_t state_q;
  logic [addr_w-1:0] idx_q;
  logic last;
  // Markers of the read in flight, aligned with deq_dout
  logic s1_vld_q;
  logic s1_sop_q;
  logic s1_eop_q;
  logic s1_err_q;

  // Read only once the memory routes this bank to us
  assign deq_en   = (state_q == deq_unload) && (deq_status == bank_unloading);
  assign deq_addr = idx_q;
  assign last     = ({1'b0, idx_q} + cnt_w'(1)) == deq_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= deq_idle;
      unload_start <= 1'b0;
      unload_done  <= 1'b0;
      idx_q        <= '0;
    end else begin
      unload_start <= 1'b0;
      unload_done  <= 1'b0;
      case (state_q)
        deq_idle: begin
          if (deq_status == bank_sorted) begin
            unload_start <= 1'b1;
            idx_q        <= '0;
            state_q      <= deq_unload;
          end
        end
        deq_unload: begin
          // One read per cycle, in address order
          if (deq_en) begin
            if (last) begin
              unload_done <= 1'b1;
              state_q     <= deq_idle;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        default: state_q <= deq_idle;
      endcase
    end
  end

  // Stage one delays markers, stage two registers the stream
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld_q <= 1'b0;
      s1_sop_q <= 1'b0;
      s1_eop_q <= 1'b0;
      s1_err_q <= 1'b0;
      out_vld  <= 1'b0;
      out_sop  <= 1'b0;
      out_eop  <= 1'b0;
      out_err  <= 1'b0;
    end else begin
      s1_vld_q <= deq_en;
      s1_sop_q <= deq_en && (idx_q == '0);
      s1_eop_q <= deq_en && last;
      // Overflow shows only on the last word
      s1_err_q <= deq_en && last && deq_err;
      out_vld  <= s1_vld_q;
      out_sop  <= s1_sop_q;
      out_eop  <= s1_eop_q;
      out_err  <= s1_err_q;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld_q) begin
      out_dat <= deq_dout;
    end
  end

endmodule

/* source/qs_bank_mem.sv */
module qs_bank_mem #(
  parameter int word_width = 32,
  parameter int max_words  = 16,
  parameter int bank_count = 2,
  localparam int addr_w = $clog2(max_words),
  localparam int bank_w = (bank_count > 1) ? $clog2(bank_count) : 1
) (
  input  logic                  clk,
  input  qs_pkg::bank_status_t  bank_status_all [bank_count],
  input  logic [bank_w-1:0]     enq_bank,
  input  logic [bank_w-1:0]     sort_bank,
  input  logic [bank_w-1:0]     deq_bank,
  input  logic                  enq_en,
  input  logic                  enq_wen,
  input  logic [addr_w-1:0]     enq_addr,
  input  logic [word_width-1:0] enq_din,
  input  logic                  sort_en,
  input  logic                  sort_wen,
  input  logic [addr_w-1:0]     sort_addr,
  input  logic [word_width-1:0] sort_din,
  input  logic                  deq_en,
  input  logic [addr_w-1:0]     deq_addr,
  output logic [word_width-1:0] sort_dout,
  output logic [word_width-1:0] deq_dout
);
  import qs_pkg::*;

  logic [word_width-1:0] bank_dout [bank_count];

  for (genvar g = 0; g < bank_count; g++) begin : g_bank
    logic [word_width-1:0] mem_q [max_words];
    logic [word_width-1:0] rd_q;
    logic en;
    logic wen;
    logic [addr_w-1:0] addr;
    logic [word_width-1:0] din;

    // Port owner follows the bank status and the engine's index
    always_comb begin
      en   = 1'b0;
      wen  = 1'b0;
      addr = '0;
      din  = '0;
      case (bank_status_all[g])
        bank_loading: begin
          if (enq_bank == bank_w'(g)) begin
            en   = enq_en;
            wen  = enq_wen;
            addr = enq_addr;
            din  = enq_din;
          end
        end
        bank_sorting: begin
          if (sort_bank == bank_w'(g)) begin
            en   = sort_en;
            wen  = sort_wen;
            addr = sort_addr;
            din  = sort_din;
          end
        end
        // Unloader only reads
        bank_unloading: begin
          if (deq_bank == bank_w'(g)) begin
            en   = deq_en;
            addr = deq_addr;
          end
        end
        default: ;
      endcase
    end

    // Single port, read data held until the next read
    always_ff @(posedge clk) begin
      if (en && wen) begin
        mem_q[addr] <= din;
      end
      if (en && !wen) begin
        rd_q <= mem_q[addr];
      end
    end

    assign bank_dout[g] = rd_q;
  end

  assign sort_dout = bank_dout[sort_bank];
  assign deq_dout  = bank_dout[deq_bank];

endmodule

/* source/qs_top.sv */
module qs_top #(
  parameter int word_width = 32,
  parameter int max_words  = 16,
  parameter int bank_count = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_vld,
  // Informational only, a packet starts with the first word after an end
  input  logic                  in_sop,
  input  logic                  in_eop,
  input  logic [word_width-1:0] in_dat,
  output logic                  in_rdy,
  output logic                  out_vld,
  output logic                  out_sop,
  output logic                  out_eop,
  output logic                  out_err,
  output logic [word_width-1:0] out_dat
);
  import qs_pkg::*;

  localparam int addr_w = $clog2(max_words);
  localparam int cnt_w  = addr_w + 1;
  localparam int bank_w = (bank_count > 1) ? $clog2(bank_count) : 1;

  // Engine pulses
  logic load_start;
  logic load_done;
  logic load_err;
  logic [cnt_w-1:0] load_count;
  logic sort_start;
  logic sort_done;
  logic unload_start;
  logic unload_done;

  // Status and info of each engine's current bank
  bank_status_t enq_status;
  bank_status_t sort_status;
  bank_status_t deq_status;
  bank_status_t bank_status_all [bank_count];
  logic [cnt_w-1:0] sort_count;
  logic [cnt_w-1:0] deq_count;
  logic deq_err;
  logic [bank_w-1:0] enq_bank;
  logic [bank_w-1:0] sort_bank;
  logic [bank_w-1:0] deq_bank;

  // Memory requests per engine
  logic enq_en;
  logic enq_wen;
  logic [addr_w-1:0] enq_addr;
  logic [word_width-1:0] enq_din;
  logic sort_en;
  logic sort_wen;
  logic [addr_w-1:0] sort_addr;
  logic [word_width-1:0] sort_din;
  logic [word_width-1:0] sort_dout;
  logic deq_en;
  logic [addr_w-1:0] deq_addr;
  logic [word_width-1:0] deq_dout;

  qs_bank_ctrl #(
    .max_words (max_words),
    .bank_count(bank_count)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .load_start     (load_start),
    .load_done      (load_done),
    .load_err       (load_err),
    .load_count     (load_count),
    .sort_start     (sort_start),
    .sort_done      (sort_done),
    .unload_start   (unload_start),
    .unload_done    (unload_done),
    .enq_status     (enq_status),
    .sort_status    (sort_status),
    .deq_status     (deq_status),
    .sort_count     (sort_count),
    .deq_count      (deq_count),
    .deq_err        (deq_err),
    .enq_bank       (enq_bank),
    .sort_bank      (sort_bank),
    .deq_bank       (deq_bank),
    .bank_status_all(bank_status_all)
  );

  qs_enqueue #(
    .word_width(word_width),
    .max_words (max_words)
  ) u_enq (
    .clk       (clk),
    .rst       (rst),
    .in_vld    (in_vld),
    .in_eop    (in_eop),
    .in_dat    (in_dat),
    .in_rdy    (in_rdy),
    .enq_status(enq_status),
    .load_start(load_start),
    .load_done (load_done),
    .load_err  (load_err),
    .load_count(load_count),
    .enq_en    (enq_en),
    .enq_wen   (enq_wen),
    .enq_addr  (enq_addr),
    .enq_din   (enq_din)
  );

  qs_sorter #(
    .word_width(word_width),
    .max_words (max_words)
  ) u_sort (
    .clk        (clk),
    .rst        (rst),
    .sort_status(sort_status),
    .sort_count (sort_count),
    .sort_start (sort_start),
    .sort_done  (sort_done),
    .sort_en    (sort_en),
    .sort_wen   (sort_wen),
    .sort_addr  (sort_addr),
    .sort_din   (sort_din),
    .sort_dout  (sort_dout)
  );

  qs_dequeue #(
    .word_width(word_width),
    .max_words (max_words)
  ) u_deq (
    .clk         (clk),
    .rst         (rst),
    .deq_status  (deq_status),
    .deq_count   (deq_count),
    .deq_err     (deq_err),
    .unload_start(unload_start),
    .unload_done (unload_done),
    .deq_en      (deq_en),
    .deq_addr    (deq_addr),
    .deq_dout    (deq_dout),
    .out_vld     (out_vld),
    .out_sop     (out_sop),
    .out_eop     (out_eop),
    .out_err     (out_err),
    .out_dat     (out_dat)
  );

  qs_bank_mem #(
    .word_width(word_width),
    .max_words (max_words),
    .bank_count(bank_count)
  ) u_mem (
    .clk            (clk),
    .bank_status_all(bank_status_all),
    .enq_bank       (enq_bank),
    .sort_bank      (sort_bank),
    .deq_bank       (deq_bank),
    .enq_en         (enq_en),
    .enq_wen        (enq_wen),
    .enq_addr       (enq_addr),
    .enq_din        (enq_din),
    .sort_en        (sort_en),
    .sort_wen       (sort_wen),
    .sort_addr      (sort_addr),
    .sort_din       (sort_din),
    .deq_en         (deq_en),
    .deq_addr       (deq_addr),
    .sort_dout      (sort_dout),
    .deq_dout       (deq_dout)
  );

endmodule

/* verif/qs_tb_assert.sv */
module qs_tb_assert (
  input logic clk,
  input logic rst,
  input logic in_rdy,
  input logic out_vld,
  input logic out_sop,
  input logic out_eop,
  input logic out_err
);

  // Number of failed assertions, read by the testbench at the end
  int fail_count = 0;

  // High while an output packet has started but not yet ended
  logic pkt_open;

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_open <= 1'b0;
    end else if (out_vld) begin
      pkt_open <= !out_eop;
    end
  end

  // Markers only ride on a valid word
  a_marker_with_vld: assert property (
    @(posedge clk) disable iff (rst) (out_sop || out_eop || out_err) |-> out_vld
  ) else begin
    fail_count++;
    $error("sop, eop or err marker seen without out_vld");
  end

  // Both streams quiet right after a reset cycle
  a_quiet_after_rst: assert property (
    @(posedge clk) rst |=> (!in_rdy && !out_vld)
  ) else begin
    fail_count++;
    $error("in_rdy or out_vld high in the cycle after reset");
  end

  // First word after an end of packet opens a new one
  a_sop_after_eop: assert property (
    @(posedge clk) disable iff (rst) (out_vld && !pkt_open) |-> out_sop
  ) else begin
    fail_count++;
    $error("valid word after end of packet has no start marker");
  end

endmodule

bind qs_top qs_tb_assert u_assert (
  .clk    (clk),
  .rst    (rst),
  .in_rdy (in_rdy),
  .out_vld(out_vld),
  .out_sop(out_sop),
  .out_eop(out_eop),
  .out_err(out_err)
);

/* verif/qs_tb.sv */
module qs_tb;

  localparam int word_width = 32;
  localparam int max_words  = 16;
  localparam int bank_count = 2;
  localparam int cnt_w      = $clog2(max_words) + 1;
  localparam int seed       = 23;

  // 3 directed, 12 random, overflow plus clean follower
  localparam int total_pkts   = 17;
  localparam int reset_cycles = 10;
  localparam int drain_cycles = 40;
  // Bubble-sort worst case plus load with gaps and unload
  localparam int sort_worst     = max_words * max_words * 6;
  localparam int per_pkt        = sort_worst + 2 * (max_words + 3) + max_words + 8;
  localparam int timeout_cycles = 2 * total_pkts * per_pkt + reset_cycles + drain_cycles;

  typedef logic [word_width-1:0] word_t;
  typedef logic [cnt_w-1:0] count_t;

  logic clk = 1'b0;
  logic rst;
  logic in_vld;
  logic in_sop;
  logic in_eop;
  word_t in_dat;
  logic in_rdy;
  logic out_vld;
  logic out_sop;
  logic out_eop;
  logic out_err;
  word_t out_dat;

  // Expected stream as flat words plus per-packet length and overflow
  word_t exp_words[$];
  int exp_len[$];
  logic exp_err[$];
  int out_pos = 0;
  int pkts_sent = 0;
  int pkts_done = 0;
  int cycle_count = 0;

  qs_top #(
    .word_width(word_width),
    .max_words (max_words),
    .bank_count(bank_count)
  ) dut_i (
    .clk    (clk),
    .rst    (rst),
    .in_vld (in_vld),
    .in_sop (in_sop),
    .in_eop (in_eop),
    .in_dat (in_dat),
    .in_rdy (in_rdy),
    .out_vld(out_vld),
    .out_sop(out_sop),
    .out_eop(out_eop),
    .out_err(out_err),
    .out_dat(out_dat)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      abort_run();
    end
  endtask

  // Ascending order of the first max_words words and a flag if any were cut
  function automatic void ref_sort(input word_t words[$], output word_t sorted[$],
                                   output logic ovf);
    int pos;
    word_t w;
    sorted = {};
    ovf = words.size() > max_words;
    for (int i = 0; i < words.size() && i < max_words; i++) begin
      w = words[i];
      pos = sorted.size();
      // Insertion sort keeps equal words in arrival order
      while (pos > 0 && sorted[pos-1] > w) begin
        pos--;
      end
      sorted.insert(pos, w);
    end
  endfunction

  function automatic void fill_random(output word_t q[$], input int n);
    q = {};
    for (int i = 0; i < n; i++) begin
      q.push_back(word_t'($urandom));
    end
  endfunction

  task automatic drive_idle();
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
  endtask

  // Queue the expected result before pushing the words through the handshake
  task automatic send_packet(input word_t words[$], input logic gaps);
    word_t sorted[$];
    logic ovf;
    int idx;
    ref_sort(words, sorted, ovf);
    foreach (sorted[i]) begin
      exp_words.push_back(sorted[i]);
    end
    exp_len.push_back(sorted.size());
    exp_err.push_back(ovf);
    pkts_sent++;
    idx = 0;
    while (idx < words.size()) begin
      @(negedge clk);
      if (gaps && ($urandom % 4 == 0)) begin
        drive_idle();
      end else begin
        in_vld = 1'b1;
        in_sop = (idx == 0);
        in_eop = (idx == words.size() - 1);
        in_dat = words[idx];
        // in_rdy moves only on rising edges, so it holds through the next one
        if (in_rdy) begin
          idx++;
        end
      end
    end
    @(negedge clk);
    drive_idle();
  endtask

  // One valid output word against the head of the expected queue
  task automatic check_output_word();
    if (exp_len.size() == 0 || exp_words.size() == 0) begin
      $display("Output word at %0t arrived while no packet was outstanding", $time);
      abort_run();
    end else begin
      check_bit("out_sop", out_sop, out_pos == 0);
      check_word("out_dat", out_dat, exp_words.pop_front());
      out_pos++;
      if (out_eop) begin
        check_count("output word count", count_t'(out_pos), count_t'(exp_len[0]));
        check_bit("out_err", out_err, exp_err[0]);
        void'(exp_len.pop_front());
        void'(exp_err.pop_front());
        out_pos = 0;
        pkts_done++;
      end else begin
        check_bit("out_err", out_err, 1'b0);
        // Packet already complete without eop
        if (out_pos >= exp_len[0]) begin
          check_bit("out_eop", out_eop, 1'b1);
        end
      end
    end
  endtask

  // Registered outputs are read here before they update
  always @(posedge clk) begin
    if (!rst && out_vld) begin
      check_output_word();
    end else if (!rst && out_pos != 0) begin
      // Words of one packet leave on consecutive cycles
      check_bit("out_vld", out_vld, 1'b1);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d packets received",
               cycle_count, pkts_done, pkts_sent);
      abort_run();
    end else if (dut_i.u_assert.fail_count != 0) begin
      $display("A protocol assertion failed before %0t, see the error above", $time);
      abort_run();
    end
  end

  initial begin
    word_t pkt[$];
    int len;
    void'($urandom(seed));
    rst = 1'b1;
    in_dat = '0;
    drive_idle();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Eight random words
    fill_random(pkt, 8);
    send_packet(pkt, 1'b0);

    // Single word with sop and eop together
    fill_random(pkt, 1);
    send_packet(pkt, 1'b0);

    // Full length descending in pairs of equal words
    pkt = {};
    for (int i = 0; i < max_words; i++) begin
      pkt.push_back(word_t'(((max_words - 1 - i) / 2) * 3));
    end
    send_packet(pkt, 1'b0);

    // Random lengths with idle gaps keep several banks in flight
    repeat (12) begin
      len = 1 + int'($urandom % max_words);
      fill_random(pkt, len);
      send_packet(pkt, 1'b1);
    end

    // Overflow by three words followed by a clean packet
    fill_random(pkt, max_words + 3);
    send_packet(pkt, 1'b0);
    fill_random(pkt, 5);
    send_packet(pkt, 1'b0);

    while (pkts_done < pkts_sent) begin
      @(posedge clk);
    end
    // Catch stray words after the last packet
    repeat (drain_cycles) @(posedge clk);

    if (exp_words.size() == 0 && dut_i.u_assert.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("%0d expected words left, %0d assertion failures",
               exp_words.size(), dut_i.u_assert.fail_count);
      abort_run();
    end
  end

endmodule

/* qs.f */
source/qs_pkg.sv
source/qs_bank_ctrl.sv
source/qs_enqueue.sv
source/qs_sorter.sv
source/qs_dequeue.sv
source/qs_bank_mem.sv
source/qs_top.sv
verif/qs_tb_assert.sv
verif/qs_tb.sv

/* Bender.yml */
package:
  name: qs

sources:
  - source/qs_pkg.sv
  - source/qs_bank_ctrl.sv
  - source/qs_enqueue.sv
  - source/qs_sorter.sv
  - source/qs_dequeue.sv
  - source/qs_bank_mem.sv
  - source/qs_top.sv
  - target: simulation
    files:
      - verif/qs_tb_assert.sv
      - verif/qs_tb.sv
